// File: crc32_gen.sv
`timescale 1ns/1ns
`default_nettype none

module crc32_gen
   import eth_pkg::*;
(
   input  logic       GMII_GTX_CLK_int,
   input  logic       rst_n_i,
   input  logic       clr_i,
   input  logic       en_i,
   input  logic [7:0] byte_i,
   input  logic [1:0] sel_i,
   output logic [7:0] fcs_byte_o
);

   logic [31:0] crc_q;
   logic [31:0] fcs;

   // One byte through the reflected LFSR, bit 0 first
   function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++)
      begin
         if (r[0] ^ b[i])
            r = (r >> 1) ^ CRC_POLY;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (!rst_n_i || clr_i)
         crc_q <= CRC_INIT;
      else if (en_i)
         crc_q <= crc_step(crc_q, byte_i);
   end

   // Reflected register is already in wire bit order
   assign fcs        = ~crc_q;
   assign fcs_byte_o = fcs[{sel_i, 3'b000} +: 8];

endmodule

`default_nettype wire

// File: eth_pkg.sv
`default_nettype none

package eth_pkg;

   // GMII framing
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam int         PREAMBLE_LEN  = 7;   // Bytes before the SFD
   localparam int         IFG_LEN       = 12;  // Idle cycles between frames

   // CRC-32 of IEEE 802.3, reflected form
   localparam logic [31:0] CRC_POLY = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;
   localparam int          FCS_LEN  = 4;       // FCS bytes, LSB first

endpackage

`default_nettype wire

// File: gmii_framer.sv
`timescale 1ns/1ns
`default_nettype none

module gmii_framer
   import eth_pkg::*, tx_pkg::*;
(
   input  logic       GMII_GTX_CLK_int,
   input  logic       rst_n_i,
   input  logic       frm_req_i,
   input  tx_desc_t   frm_desc_i,
   output logic       frm_ack_o,
   output logic       crc_clr_o,
   output logic       crc_en_o,
   output logic [7:0] crc_byte_o,
   output logic [1:0] fcs_sel_o,
   input  logic [7:0] fcs_byte_i,
   output gmii_tx_t   gmii_o
);

   frm_state_t       state;
   logic [LEN_W-1:0] cnt;        // Byte or cycle count within a state
   logic [7:0]       pay_byte;

   // Descriptor is stable until the ack, so no local copy
   assign pay_byte = frm_desc_i.seed + cnt[7:0];

   // CRC control runs one cycle ahead of the registered pins
   assign crc_clr_o  = (state == FRM_PRE);
   assign crc_en_o   = (state == FRM_DATA);
   assign crc_byte_o = pay_byte;
   assign fcs_sel_o  = cnt[1:0];

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (!rst_n_i)
      begin
         state     <= FRM_IDLE;
         cnt       <= '0;
         frm_ack_o <= 1'b0;
         gmii_o    <= '0;
      end
      else
      begin
         gmii_o <= '0;   // Idle unless a state drives a byte
         unique case (state)
            FRM_IDLE:
               if (frm_req_i && !frm_ack_o)
               begin
                  cnt   <= '0;
                  state <= FRM_PRE;
               end
            FRM_PRE:
            begin
               gmii_o.txd   <= PREAMBLE_BYTE;
               gmii_o.tx_en <= 1'b1;
               if (cnt == LEN_W'(PREAMBLE_LEN - 1))
               begin
                  cnt   <= '0;
                  state <= FRM_SFD;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            FRM_SFD:
            begin
               gmii_o.txd   <= SFD_BYTE;
               gmii_o.tx_en <= 1'b1;
               state        <= FRM_DATA;
            end
            FRM_DATA:
            begin
               gmii_o.txd   <= pay_byte;
               gmii_o.tx_en <= 1'b1;
               if (cnt == frm_desc_i.length - 1'b1)   // Last payload byte
               begin
                  cnt   <= '0;
                  state <= FRM_FCS;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            FRM_FCS:
            begin
               gmii_o.txd   <= fcs_byte_i;   // CRC has folded every payload byte
               gmii_o.tx_en <= 1'b1;
               if (cnt == LEN_W'(FCS_LEN - 1))
               begin
                  cnt       <= '0;
                  frm_ack_o <= 1'b1;
                  state     <= FRM_IFG;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            FRM_IFG:
            begin
               // Gap is counted only once req has fallen
               if (frm_ack_o)
               begin
                  if (!frm_req_i)
                     frm_ack_o <= 1'b0;
               end
               else if (cnt == LEN_W'(IFG_LEN - 1))
                  state <= FRM_IDLE;
               else
                  cnt <= cnt + 1'b1;
            end
            default: state <= FRM_IDLE;
         endcase
      end
   end

   // Pins go idle only once the last FCS byte has been sent
   a_tx_en_cont: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      $fell(gmii_o.tx_en) |-> frm_ack_o);

endmodule

`default_nettype wire

// File: gmii_tx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gmii_tx_tb
   import tx_pkg::*;
();

   typedef struct packed {
      logic             src;
      logic [LEN_W-1:0] length;
      logic [7:0]       seed;
      logic [31:0]      fcs;   // Zero when the data file has no value
   } exp_frame_t;

   logic                   GMII_GTX_CLK_int;
   logic                   rst_n;
   logic     [NUM_SRC-1:0] src_req;
   tx_desc_t [NUM_SRC-1:0] src_desc;
   logic     [NUM_SRC-1:0] src_ack;
   gmii_tx_t               gmii;

   logic [31:0]        tdata [0:159];   // Five words per frame
   exp_frame_t         exp_q [$];       // Frames in the order they must appear
   logic [7:0]         burst [$];
   logic [NUM_SRC-1:0] frame_done = '0;
   logic [NUM_SRC-1:0] ack_prev = '0;
   logic [NUM_SRC-1:0] req_prev = '0;
   logic               tx_en_prev = 1'b0;
   logic               seen_burst = 1'b0;
   src_idx_t           last_served = 1'b0;   // Source 0 counts as served at reset
   int                 gap_cnt = 0;
   int                 frames_seen = 0;
   int                 cycle_cnt = 0;
   int                 timeout_lim = 0;

   tb_clk_gen clk_gen_inst (.clk_o(GMII_GTX_CLK_int), .rst_n_o(rst_n));

   gmii_tx_top gmii_tx_top_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n),
      .src_req_i        (src_req),
      .src_desc_i       (src_desc),
      .src_ack_o        (src_ack),
      .gmii_o           (gmii)
   );

   task automatic check_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      if (exp_v !== act_v)
      begin
         $display("[FAIL] %s: expected %0h, actual %0h", name, exp_v, act_v);
         $display("*** TEST FAILED ***");
         $fatal(1, "Check %s did not match", name);
      end
   endtask

   // Bit-serial CRC-32 in normal form, bits fed in wire order
   function automatic logic [31:0] fcs_model(input logic [LEN_W-1:0] len,
                                             input logic [7:0] seed);
      logic [31:0] c;
      logic [31:0] r;
      logic [7:0]  b;
      c = 32'hFFFFFFFF;
      for (int i = 0; i < int'(len); i++)
      begin
         b = 8'(seed + i);
         for (int j = 0; j < 8; j++)
         begin
            if (c[31] ^ b[j])
               c = (c << 1) ^ 32'h04C11DB7;
            else
               c = c << 1;
         end
      end
      c = ~c;
      for (int j = 0; j < 32; j++)
         r[j] = c[31-j];   // First bit on the wire lands in bit 0
      return r;
   endfunction

   function automatic exp_frame_t load_frame(input int idx);
      exp_frame_t f;
      f.src    = tdata[5*idx][0];
      f.length = tdata[5*idx+1][LEN_W-1:0];
      f.seed   = tdata[5*idx+2][7:0];
      f.fcs    = tdata[5*idx+4];
      return f;
   endfunction

   task automatic tick();
      @(posedge GMII_GTX_CLK_int);
      #2;
   endtask

   task automatic offer(input exp_frame_t f);
      src_desc[f.src] = tx_desc_t'({f.length, f.seed});
      src_req[f.src]  = 1'b1;
   endtask

   task automatic finish_handshake(input src_idx_t s);
      do
         tick();
      while (!src_ack[s]);
      src_req[s] = 1'b0;
      do
         tick();
      while (src_ack[s]);
   endtask

   task automatic send_single(input exp_frame_t f);
      exp_q.push_back(f);
      offer(f);
      finish_handshake(f.src);
      last_served = f.src;
   endtask

   // Both reqs rise together, the source not served last goes first
   task automatic send_pair(input exp_frame_t a, input exp_frame_t b);
      exp_frame_t first;
      exp_frame_t second;
      check_value("paired lines name both sources", 1, a.src != b.src);
      if (a.src == ~last_served)
      begin
         first  = a;
         second = b;
      end
      else
      begin
         first  = b;
         second = a;
      end
      exp_q.push_back(first);
      exp_q.push_back(second);
      offer(a);
      offer(b);
      finish_handshake(first.src);
      finish_handshake(second.src);
      last_served = second.src;
   endtask

   task automatic check_burst();
      exp_frame_t  e;
      string       nm;
      int          n;
      logic [31:0] act_fcs;
      check_value("burst matches an offered frame", 1, exp_q.size() != 0);
      e  = exp_q.pop_front();
      nm = $sformatf("frame %0d src %0d len %0d", frames_seen, e.src, e.length);
      n  = burst.size();
      check_value({nm, " burst length"}, 12 + e.length, n);
      for (int i = 0; i < 7; i++)
         check_value({nm, " preamble"}, 8'h55, burst[i]);
      check_value({nm, " SFD"}, 8'hD5, burst[7]);
      for (int i = 0; i < int'(e.length); i++)
         check_value({nm, " payload"}, 8'(e.seed + i), burst[8+i]);
      act_fcs = {burst[n-1], burst[n-2], burst[n-3], burst[n-4]};   // LSB first on the wire
      if (e.fcs != 0)
         check_value({nm, " FCS from data file"}, e.fcs, act_fcs);
      check_value({nm, " FCS from CRC model"}, fcs_model(e.length, e.seed), act_fcs);
      frame_done[e.src] = 1'b1;
      frames_seen++;
      burst.delete();
   endtask

   // Outputs sampled mid-cycle, away from both clock edges
   always @(negedge GMII_GTX_CLK_int)
   begin
      if (!rst_n)
      begin
         check_value("tx_en during reset", 0, gmii.tx_en);
         check_value("txd during reset", 0, gmii.txd);
         check_value("acks during reset", 0, src_ack);
      end
      else
      begin
         if (gmii.tx_en)
         begin
            if (!tx_en_prev && seen_burst)
               check_value("gap of at least 12 idle cycles", 1, gap_cnt >= 12);
            burst.push_back(gmii.txd);
         end
         else if (tx_en_prev)
         begin
            check_burst();
            seen_burst = 1'b1;
            gap_cnt    = 1;
         end
         else
            gap_cnt++;
         for (int k = 0; k < NUM_SRC; k++)
         begin
            if (src_ack[k] && !ack_prev[k])
            begin
               check_value("ack only after that source's last FCS byte", 1, frame_done[k]);
               check_value("ack rises while req is high", 1, req_prev[k]);
               frame_done[k] = 1'b0;
            end
            if (!src_ack[k] && ack_prev[k])
               check_value("ack falls only after req dropped", 0, req_prev[k]);
         end
         check_value("at most one ack high", 1, $onehot0(src_ack));
      end
      tx_en_prev = gmii.tx_en;
      ack_prev   = src_ack;
      req_prev   = src_req;
   end

   always @(posedge GMII_GTX_CLK_int)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (timeout_lim != 0 && cycle_cnt > timeout_lim)
      begin
         $display("Timeout: the frames were not all sent within %0d cycles", timeout_lim);
         $display("*** TEST FAILED ***");
         $fatal(1, "Simulation timed out");
      end
   end

   initial
   begin
      int n_frames;
      int idx;
      src_req  = '0;
      src_desc = '0;
      void'($urandom(3));
      for (int i = 0; i < 160; i++)
         tdata[i] = '1;   // Marks the end of the data
      $readmemh("gmii_tx_testdata.txt", tdata);
      n_frames = 0;
      while (n_frames < 32 && tdata[5*n_frames] != '1)
      begin
         timeout_lim += tdata[5*n_frames+1] + 44;
         n_frames++;
      end
      timeout_lim += 16 + 200;
      @(posedge rst_n);
      tick();
      idx = 0;
      while (idx < n_frames)
      begin
         if (tdata[5*idx+3][0] && idx + 1 < n_frames)
         begin
            send_pair(load_frame(idx), load_frame(idx + 1));
            idx += 2;
         end
         else
         begin
            send_single(load_frame(idx));
            idx++;
         end
         repeat ($urandom_range(20, 0)) tick();
      end
      if (frames_seen == n_frames && exp_q.size() == 0)
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
      else
      begin
         $display("Only %0d of %0d frames were seen on GMII", frames_seen, n_frames);
         $display("*** TEST FAILED ***");
         $fatal(1, "Frames missing at the end of the run");
      end
   end

endmodule

`default_nettype wire

// File: gmii_tx_testdata.txt
// Columns in hex: source, length, seed, simultaneous flag, expected FCS (0 = none given)
// Flagged lines come in pairs whose reqs rise in the same cycle
0 040 11 1 00000000
1 02E 22 1 00000000
0 001 61 0 E8B7BE43
1 001 00 0 D202EF8D
0 003 61 0 352441C2
1 009 31 0 CBF43926
0 0FF 80 0 00000000
1 100 00 0 29058C73
1 7FF 3C 1 00000000
0 001 F0 1 00000000
0 02E 17 0 00000000
0 040 A5 1 00000000
1 003 5A 1 00000000

// File: gmii_tx_top.f
eth_pkg.sv
tx_pkg.sv
crc32_gen.sv
tx_arbiter.sv
gmii_framer.sv
gmii_tx_top.sv
tb_clk_gen.sv
gmii_tx_tb.sv

// File: gmii_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module gmii_tx_top
   import tx_pkg::*;
(
   input  logic                   GMII_GTX_CLK_int,
   input  logic                   rst_n_i,
   input  logic     [NUM_SRC-1:0] src_req_i,
   input  tx_desc_t [NUM_SRC-1:0] src_desc_i,
   output logic     [NUM_SRC-1:0] src_ack_o,
   output gmii_tx_t               gmii_o
);

   logic       frm_req;
   tx_desc_t   frm_desc;
   logic       frm_ack;
   logic       crc_clr;
   logic       crc_en;
   logic [7:0] crc_byte;
   logic [1:0] fcs_sel;
   logic [7:0] fcs_byte;

   tx_arbiter arbiter_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .src_req_i        (src_req_i),
      .src_desc_i       (src_desc_i),
      .src_ack_o        (src_ack_o),
      .frm_req_o        (frm_req),
      .frm_desc_o       (frm_desc),
      .frm_ack_i        (frm_ack)
   );

   gmii_framer framer_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .frm_req_i        (frm_req),
      .frm_desc_i       (frm_desc),
      .frm_ack_o        (frm_ack),
      .crc_clr_o        (crc_clr),
      .crc_en_o         (crc_en),
      .crc_byte_o       (crc_byte),
      .fcs_sel_o        (fcs_sel),
      .fcs_byte_i       (fcs_byte),
      .gmii_o           (gmii_o)
   );

   crc32_gen crc_inst (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .clr_i            (crc_clr),
      .en_i             (crc_en),
      .byte_i           (crc_byte),
      .sel_i            (fcs_sel),
      .fcs_byte_o       (fcs_byte)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run from the project root, exit status follows the testbench
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -Wno-fatal --top-module gmii_tx_tb \
      -f gmii_tx_top.f \
   && ./obj_dir/Vgmii_tx_tb \
   || { echo "Simulation failed"; exit 1; }

// File: tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;   // 40 ns period
   end

   // Reset held for 16 rising edges, released just after an edge
   initial
   begin
      rst_n_o = 1'b0;
      repeat (16) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: tx_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tx_arbiter
   import tx_pkg::*;
(
   input  logic                   GMII_GTX_CLK_int,
   input  logic                   rst_n_i,
   input  logic     [NUM_SRC-1:0] src_req_i,
   input  tx_desc_t [NUM_SRC-1:0] src_desc_i,
   output logic     [NUM_SRC-1:0] src_ack_o,
   output logic                   frm_req_o,
   output tx_desc_t               frm_desc_o,
   input  logic                   frm_ack_i
);

   arb_state_t state;
   src_idx_t   grant;      // Source currently being served
   src_idx_t   last_srv;   // Source served most recently
   src_idx_t   winner;

   // Round robin, a tie goes to the source not served last
   always_comb
   begin
      if (src_req_i[0] && src_req_i[1])
         winner = ~last_srv;
      else if (src_req_i[1])
         winner = 1'b1;
      else
         winner = 1'b0;
   end

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (!rst_n_i)
      begin
         state     <= ARB_IDLE;
         grant     <= 1'b0;
         last_srv  <= 1'b0;   // So source 1 wins the first tie
         frm_req_o <= 1'b0;
         src_ack_o <= '0;
      end
      else
      begin
         unique case (state)
            ARB_IDLE:
               if (|src_req_i && !frm_ack_i)
               begin
                  grant     <= winner;
                  frm_req_o <= 1'b1;
                  state     <= ARB_BUSY;
               end
            ARB_BUSY:
               if (frm_ack_i)   // Last FCS byte is out
               begin
                  frm_req_o        <= 1'b0;
                  src_ack_o[grant] <= 1'b1;
                  last_srv         <= grant;
                  state            <= ARB_RELEASE;
               end
            ARB_RELEASE:
               if (!src_req_i[grant])
               begin
                  src_ack_o <= '0;
                  state     <= ARB_IDLE;
               end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   // Descriptor held for the whole frame
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (state == ARB_IDLE && |src_req_i)
         frm_desc_o <= src_desc_i[winner];
   end

   a_one_ack: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      $onehot0(src_ack_o));

   a_idle_no_ack: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
      (state == ARB_IDLE && !frm_req_o) |-> (src_ack_o == '0));

endmodule

`default_nettype wire

// File: tx_pkg.sv
`default_nettype none

package tx_pkg;

   localparam int LEN_W   = 11;  // Payload length field, 1 to 2047
   localparam int NUM_SRC = 2;

   // Frame descriptor offered by a source
   typedef struct packed {
      logic [LEN_W-1:0] length;
      logic [7:0]       seed;   // Payload byte i is seed + i
   } tx_desc_t;

   // Registered GMII transmit pins
   typedef struct packed {
      logic [7:0] txd;
      logic       tx_en;
   } gmii_tx_t;

   typedef logic src_idx_t;     // One bit covers both sources

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_BUSY,     // Framer owns the granted descriptor
      ARB_RELEASE   // Waiting for the source to drop req
   } arb_state_t;

   typedef enum logic [2:0] {
      FRM_IDLE,
      FRM_PRE,
      FRM_SFD,
      FRM_DATA,
      FRM_FCS,
      FRM_IFG
   } frm_state_t;

endpackage

`default_nettype wire
